/* filelist.f */
+incdir+verilog
verilog/redirect_pkg.sv
verilog/redirect_ifs.sv
verilog/csrBank.sv
verilog/trapVectorCalc.sv
verilog/resumeTargetCalc.sv
verilog/redirectCombiner.sv
verilog/redirectTop.sv
verif/redirect_properties.sv
verif/tb_redirect.sv

/* run.sh */
#!/bin/sh
# build and run the redirect testbench with verilator.
# the verdict comes from run.log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_redirect \
    -f filelist.f -o simRedirect > run.log 2>&1 \
    && ./obj_dir/simRedirect >> run.log 2>&1 \
    || echo "Testbench failed" >> run.log
cat run.log
grep -q "Testbench failed" run.log && exit 1 || exit 0

/* verif/redirect_properties.sv */
`timescale 1ns/100ps
`include "redirect_params.svh"

// handshake checks on the redirect path.
module redirect_properties (
    input logic                   clk,
    input logic                   rstN,
    input logic                   reqReady,
    input logic                   redirValid,
    input logic                   redirReady,
    input logic [`REDIR_XLEN-1:0] redirPc,
    input logic                   vecHeld,
    input logic                   resHeld
);

    // combiner register empties under reset.
    resetEmpty: assert property (@(posedge clk) !rstN |=> !redirValid)
        else $error("redirValid still high after a reset cycle");

    // fetch stalled, so the offer must not move.
    holdRedirect: assert property (@(posedge clk) disable iff (!rstN)
        redirValid && !redirReady |=> redirValid && $stable(redirPc))
        else $error("redirect changed while redirReady was low");

    // all three slots full, nothing more fits.
    fullBlocks: assert property (@(posedge clk) disable iff (!rstN)
        redirValid && !redirReady && vecHeld && resHeld |-> !reqReady)
        else $error("reqReady high with every stage full and fetch stalled");

endmodule

bind redirectTop redirect_properties props (
    .clk        (clk),
    .rstN       (rstN),
    .reqReady   (reqReady),
    .redirValid (redirValid),
    .redirReady (redirReady),
    .redirPc    (redirPc),
    .vecHeld    (vecTarget.valid),
    .resHeld    (resTarget.valid)
);

/* verif/redirect_stim.txt */
# W sel data together : csr write, together=1 issues it in the cycle the next request is taken
# R flags(trap ret flush) priv irq code flushTarget expectedPc, no expectedPc when flags is 0
W 0 80001000 0
W 1 40002002 0
W 2 00003000 0
W 3 80000101 0
W 4 40000203 0
W 5 00000406 0
R 4 3 0 0 00000000 80001000
R 4 1 0 0 00000000 40002000
R 4 0 0 0 00000000 00003000
R 2 3 0 0 00000000 80000100
R 2 1 0 0 00000000 40000202
R 2 0 0 0 00000000 00000406
R 1 3 0 0 20000007 20000004
W 0 80004001 0
R 4 3 1 5 00000000 80004014
R 4 3 0 5 00000000 80004000
R 4 3 1 f 00000000 8000403c
R 7 1 0 0 11111111 40002000
R 3 0 0 0 11111111 00000406
R 5 3 1 2 2222222b 80004008
R 0 3 0 0 33333333
R 1 1 0 0 4444444e 4444444c
W 0 80008000 1
R 4 3 0 0 00000000 80004000
R 4 3 0 0 00000000 80008000
W 4 55555555 1
R 2 1 0 0 00000000 40000202
R 2 1 0 0 00000000 55555554
R 4 0 1 3 00000000 00003000

/* verif/tb_redirect.sv */
`timescale 1ns/100ps
`include "redirect_params.svh"

module tb_redirect;

    logic                    clk;
    logic                    rstN;
    logic                    csrWe;
    logic [2:0]              csrSel;
    logic [`REDIR_XLEN-1:0]  csrWdata;
    logic                    reqValid;
    logic                    reqTrap;
    logic                    reqTrapReturn;
    logic                    reqFlush;
    logic [1:0]              reqPriv;
    logic                    reqIsInterrupt;
    logic [`REDIR_CODEW-1:0] reqCode;
    logic [`REDIR_XLEN-1:0]  reqFlushTarget;
    logic                    redirReady;
    logic                    reqReady;
    logic                    redirValid;
    logic [`REDIR_XLEN-1:0]  redirPc;

    // expected redirect pcs, oldest first.
    logic [`REDIR_XLEN-1:0]  expQ[$];
    logic [31:0]             readySeed;
    logic [31:0]             gapSeed;
    // csr write held back for the next request.
    logic                    pendWe;
    logic [2:0]              pendSel;
    logic [`REDIR_XLEN-1:0]  pendData;
    int                      lineCount;

    redirectTop u_dut (
        .clk            (clk),
        .rstN           (rstN),
        .csrWe          (csrWe),
        .csrSel         (csrSel),
        .csrWdata       (csrWdata),
        .reqValid       (reqValid),
        .reqTrap        (reqTrap),
        .reqTrapReturn  (reqTrapReturn),
        .reqFlush       (reqFlush),
        .reqPriv        (reqPriv),
        .reqIsInterrupt (reqIsInterrupt),
        .reqCode        (reqCode),
        .reqFlushTarget (reqFlushTarget),
        .redirReady     (redirReady),
        .reqReady       (reqReady),
        .redirValid     (redirValid),
        .redirPc        (redirPc)
    );

    // 8 ns clock.
    always #4 clk = ~clk;

    // lcg step.
    function automatic logic [31:0] nextRand(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run aborted");
    endtask

    // one write, visible from the following cycle.
    task automatic writeCsr(input logic [2:0] sel, input logic [31:0] data);
        @(posedge clk);
        csrWe    <= 1'b1;
        csrSel   <= sel;
        csrWdata <= data;
        @(posedge clk);
        csrWe    <= 1'b0;
    endtask

    task automatic sendRequest(input logic [2:0] flags, input logic [1:0] priv,
                               input logic irq, input logic [3:0] code,
                               input logic [31:0] flushTgt, input logic [31:0] expPc);
        int gap;
        gapSeed = nextRand(gapSeed);
        gap = gapSeed[31:16] % 3;
        repeat (gap) @(posedge clk);
        if (pendWe) begin
            // idle cycle with reqReady high, so both side stages are empty now.
            // the request is then sure to be taken on the next edge.
            do @(posedge clk); while (!reqReady);
            csrWe    <= 1'b1;
            csrSel   <= pendSel;
            csrWdata <= pendData;
        end else begin
            @(posedge clk);
        end
        reqValid       <= 1'b1;
        reqTrap        <= flags[2];
        reqTrapReturn  <= flags[1];
        reqFlush       <= flags[0];
        reqPriv        <= priv;
        reqIsInterrupt <= irq;
        reqCode        <= code;
        reqFlushTarget <= flushTgt;
        // held until the beat is taken.
        do @(posedge clk); while (!reqReady);
        if (flags != 0) begin
            expQ.push_back(expPc);
        end
        reqValid <= 1'b0;
        csrWe    <= 1'b0;
        pendWe = 1'b0;
    endtask

    // fetch stalls about a third of the time.
    always @(posedge clk) begin
        readySeed = nextRand(readySeed);
        redirReady <= (readySeed[31:16] % 3) != 0;
    end

    // scoreboard, one entry per redirect transfer.
    always @(posedge clk) begin
        if (rstN && redirValid && redirReady) begin
            if (expQ.size() == 0) begin
                failRun("a redirect arrived with no request waiting for one");
            end else begin
                checkValue("redirPc", redirPc, expQ.pop_front());
            end
        end
    end

    // budget of 40 cycles per stimulus line.
    initial begin
        wait (lineCount != 0);
        repeat (lineCount * 40) @(posedge clk);
        failRun("timeout, the redirect path stopped making progress and the run hung");
    end

    initial begin
        int               fd;
        int               n;
        int               count;
        logic [63:0]      kind;
        logic [8*160-1:0] lineBuf;
        int               sel;
        int               data;
        int               together;
        int               flags;
        int               priv;
        int               irq;
        int               code;
        int               flushTgt;
        int               expPc;
        int               drainLeft;
        clk = 1'b0;
        rstN           <= 1'b0;
        csrWe          <= 1'b0;
        csrSel         <= '0;
        csrWdata       <= '0;
        reqValid       <= 1'b0;
        reqTrap        <= 1'b0;
        reqTrapReturn  <= 1'b0;
        reqFlush       <= 1'b0;
        reqPriv        <= '0;
        reqIsInterrupt <= 1'b0;
        reqCode        <= '0;
        reqFlushTarget <= '0;
        redirReady     <= 1'b0;
        readySeed = 32'h6d42;
        gapSeed = nextRand(32'h6d42);
        pendWe = 1'b0;
        pendSel = '0;
        pendData = '0;
        lineCount = 0;
        // line count sets the watchdog budget.
        count = 0;
        fd = $fopen("verif/redirect_stim.txt", "r");
        if (fd == 0) begin
            failRun("cannot open the stimulus file verif/redirect_stim.txt");
        end
        while ($fgets(lineBuf, fd) != 0) begin
            count++;
        end
        $fclose(fd);
        lineCount = count;
        fd = $fopen("verif/redirect_stim.txt", "r");
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        while (1) begin
            kind = '0;
            n = $fscanf(fd, "%s", kind);
            if (n != 1) begin
                break;
            end
            if (kind[7:0] == "#") begin
                n = $fgets(lineBuf, fd);
            end else if (kind[7:0] == "W") begin
                n = $fscanf(fd, "%h %h %h", sel, data, together);
                if (together != 0) begin
                    pendWe = 1'b1;
                    pendSel = sel[2:0];
                    pendData = data;
                end else begin
                    writeCsr(sel[2:0], data);
                end
            end else if (kind[7:0] == "R") begin
                n = $fscanf(fd, "%h %h %h %h %h", flags, priv, irq, code, flushTgt);
                // no flag, no expected pc on the line.
                expPc = 0;
                if (flags != 0) begin
                    n = $fscanf(fd, "%h", expPc);
                end
                sendRequest(flags[2:0], priv[1:0], irq[0], code[3:0], flushTgt, expPc);
            end else begin
                failRun("the stimulus file holds a line of unknown kind");
            end
        end
        $fclose(fd);
        // drain, at most three redirects are still in flight.
        drainLeft = 100;
        while (expQ.size() != 0 && drainLeft > 0) begin
            @(posedge clk);
            drainLeft--;
        end
        // a few more cycles to catch a duplicate.
        repeat (8) @(posedge clk);
        if (expQ.size() != 0) begin
            failRun("some expected redirects never arrived");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

/* verilog/csrBank.sv */
`timescale 1ns/100ps
`include "redirect_params.svh"

module csrBank import redirect_pkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   csrWe,
    input  logic [2:0]             csrSel,
    input  logic [`REDIR_XLEN-1:0] csrWdata,
    csrViewIf.bank                 view
);

    tvecU                   mtvecQ;
    tvecU                   stvecQ;
    tvecU                   utvecQ;
    logic [`REDIR_XLEN-1:0] mepcQ;
    logic [`REDIR_XLEN-1:0] sepcQ;
    logic [`REDIR_XLEN-1:0] uepcQ;

    // incoming word seen as a trap vector.
    tvecU                   wrVec;
    // epc values are always halfword aligned.
    logic [`REDIR_XLEN-1:0] wrEpc;

    assign wrVec.raw = csrWdata;
    assign wrEpc     = {csrWdata[`REDIR_XLEN-1:1], 1'b0};

    // new value visible the cycle after csrWe.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            mtvecQ <= '0;
            stvecQ <= '0;
            utvecQ <= '0;
            mepcQ  <= '0;
            sepcQ  <= '0;
            uepcQ  <= '0;
        end else if (csrWe) begin
            case (csrSel)
                `CSR_SEL_MTVEC: mtvecQ <= wrVec;
                `CSR_SEL_STVEC: stvecQ <= wrVec;
                `CSR_SEL_UTVEC: utvecQ <= wrVec;
                `CSR_SEL_MEPC:  mepcQ  <= wrEpc;
                `CSR_SEL_SEPC:  sepcQ  <= wrEpc;
                `CSR_SEL_UEPC:  uepcQ  <= wrEpc;
                // unused selectors are ignored.
                default: ;
            endcase
        end
    end

    // view port.
    assign view.mtvec = mtvecQ;
    assign view.stvec = stvecQ;
    assign view.utvec = utvecQ;
    assign view.mepc  = mepcQ;
    assign view.sepc  = sepcQ;
    assign view.uepc  = uepcQ;

endmodule

/* verilog/redirectCombiner.sv */
`timescale 1ns/100ps
`include "redirect_params.svh"

module redirectCombiner (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   redirReady,
    targetIf.dst                   vec,
    targetIf.dst                   res,
    output logic                   redirValid,
    output logic [`REDIR_XLEN-1:0] redirPc
);

    logic                   pairValid;
    logic                   regFree;
    logic                   consume;
    logic                   anyTake;
    logic [`REDIR_XLEN-1:0] pickPc;
    logic                   validQ;
    logic [`REDIR_XLEN-1:0] pcQ;

    // both sides were loaded by the same request.
    assign pairValid = vec.valid && res.valid;
    // output register empty or leaving now.
    assign regFree   = !validQ || redirReady;
    assign consume   = pairValid && regFree;

    // pop both sides together.
    assign vec.ready = consume;
    assign res.ready = consume;

    // trap over return over flush.
    // res already ordered return over flush.
    assign anyTake = vec.take || res.take;
    assign pickPc  = vec.take ? vec.target : res.target;

    // a pair with no take is dropped here.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (consume) begin
            validQ <= anyTake;
        end else if (redirReady) begin
            validQ <= 1'b0;
        end
    end

    // pc held while fetch stalls.
    always_ff @(posedge clk) begin
        if (consume && anyTake) begin
            pcQ <= pickPc;
        end
    end

    assign redirValid = validQ;
    assign redirPc    = pcQ;

endmodule

/* verilog/redirectTop.sv */
`timescale 1ns/100ps
`include "redirect_params.svh"

module redirectTop import redirect_pkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    csrWe,
    input  logic [2:0]              csrSel,
    input  logic [`REDIR_XLEN-1:0]  csrWdata,
    input  logic                    reqValid,
    input  logic                    reqTrap,
    input  logic                    reqTrapReturn,
    input  logic                    reqFlush,
    input  logic [1:0]              reqPriv,
    input  logic                    reqIsInterrupt,
    input  logic [`REDIR_CODEW-1:0] reqCode,
    input  logic [`REDIR_XLEN-1:0]  reqFlushTarget,
    input  logic                    redirReady,
    output logic                    reqReady,
    output logic                    redirValid,
    output logic [`REDIR_XLEN-1:0]  redirPc
);

    reqFlagsT reqFlags;
    logic     vecReady;
    logic     resReady;

    csrViewIf csrView ();
    targetIf  vecTarget ();
    targetIf  resTarget ();

    // request flags as one word.
    assign reqFlags.trap        = reqTrap;
    assign reqFlags.trapReturn  = reqTrapReturn;
    assign reqFlags.flush       = reqFlush;
    assign reqFlags.priv        = privT'(reqPriv);
    assign reqFlags.isInterrupt = reqIsInterrupt;

    // accept only when both side stages have room.
    assign reqReady = vecReady && resReady;

    csrBank bank (
        .clk, .rstN, .csrWe, .csrSel, .csrWdata,
        .view (csrView.bank)
    );

    trapVectorCalc vecCalc (
        .clk, .rstN,
        .inValid (reqValid), .flags (reqFlags), .code (reqCode), .inReady (vecReady),
        .view (csrView.vector), .out (vecTarget.src)
    );

    resumeTargetCalc resCalc (
        .clk, .rstN,
        .inValid (reqValid), .flags (reqFlags), .flushTarget (reqFlushTarget),
        .inReady (resReady), .view (csrView.resume), .out (resTarget.src)
    );

    redirectCombiner combiner (
        .clk, .rstN, .redirReady,
        .vec (vecTarget.dst), .res (resTarget.dst),
        .redirValid, .redirPc
    );

endmodule

/* verilog/redirect_ifs.sv */
`timescale 1ns/100ps
`include "redirect_params.svh"

// current csr state, bank to both side units.
// no handshake, plain register outputs.
interface csrViewIf import redirect_pkg::*; ();
    tvecU                   mtvec;
    tvecU                   stvec;
    tvecU                   utvec;
    logic [`REDIR_XLEN-1:0] mepc;
    logic [`REDIR_XLEN-1:0] sepc;
    logic [`REDIR_XLEN-1:0] uepc;

    modport bank   (output mtvec, stvec, utvec, mepc, sepc, uepc);
    modport vector (input mtvec, stvec, utvec);
    modport resume (input mepc, sepc, uepc);
endinterface

// side unit result towards the combiner.
// held by the source until valid and ready meet.
interface targetIf ();
    logic                   valid;
    logic                   ready;
    logic                   take;
    logic [`REDIR_XLEN-1:0] target;

    modport src (output valid, take, target, input ready);
    modport dst (input valid, take, target, output ready);
endinterface

/* verilog/redirect_params.svh */
`ifndef REDIRECT_PARAMS_SVH
`define REDIRECT_PARAMS_SVH

// address and csr value width.
`define REDIR_XLEN 32

// cause code width, as seen by vectored mode.
`define REDIR_CODEW 4

// csr write port selector codes.
// trap-vector registers first.
`define CSR_SEL_MTVEC 3'd0
`define CSR_SEL_STVEC 3'd1
`define CSR_SEL_UTVEC 3'd2
// then the exception pcs.
`define CSR_SEL_MEPC 3'd3
`define CSR_SEL_SEPC 3'd4
`define CSR_SEL_UEPC 3'd5

`endif

/* verilog/redirect_pkg.sv */
`include "redirect_params.svh"

package redirect_pkg;

    // privilege levels, rv encoding.
    // 2'd2 is reserved.
    typedef enum logic [1:0] {
        privUser       = 2'd0,
        privSupervisor = 2'd1,
        privMachine    = 2'd3
    } privT;

    // xtvec word.
    // written raw, read back as base and mode.
    typedef union packed {
        logic [`REDIR_XLEN-1:0] raw;
        struct packed {
            logic [`REDIR_XLEN-3:0] base;
            logic [1:0]             mode;
        } fields;
    } tvecU;

    // request flags, one per accepted beat.
    // any mix of the three kinds may be set.
    typedef struct packed {
        logic trap;
        logic trapReturn;
        logic flush;
        privT priv;
        logic isInterrupt;
    } reqFlagsT;

endpackage

/* verilog/resumeTargetCalc.sv */
`timescale 1ns/100ps
`include "redirect_params.svh"

module resumeTargetCalc import redirect_pkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   inValid,
    input  reqFlagsT               flags,
    input  logic [`REDIR_XLEN-1:0] flushTarget,
    output logic                   inReady,
    csrViewIf.resume               view,
    targetIf.src                   out
);

    logic [`REDIR_XLEN-1:0] epc;
    logic [`REDIR_XLEN-1:0] resTarget;
    logic                   validQ;
    logic                   takeQ;
    logic [`REDIR_XLEN-1:0] targetQ;

    // epc of the level being left.
    always_comb begin
        unique case (flags.priv)
            privMachine:    epc = view.mepc;
            privSupervisor: epc = view.sepc;
            privUser:       epc = view.uepc;
            default:        epc = '0;
        endcase
    end

    // trap return beats a plain flush.
    assign resTarget = flags.trapReturn ? epc :
                       {flushTarget[`REDIR_XLEN-1:2], 2'b00};

    assign inReady = !validQ || out.ready;

    // same flow as the vector stage, so both stay in step.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (inValid && inReady) begin
            validQ <= 1'b1;
        end else if (out.ready) begin
            validQ <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            takeQ   <= flags.trapReturn || flags.flush;
            targetQ <= resTarget;
        end
    end

    assign out.valid  = validQ;
    assign out.take   = takeQ;
    assign out.target = targetQ;

endmodule

/* verilog/trapVectorCalc.sv */
`timescale 1ns/100ps
`include "redirect_params.svh"

module trapVectorCalc import redirect_pkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    inValid,
    input  reqFlagsT                flags,
    input  logic [`REDIR_CODEW-1:0] code,
    output logic                    inReady,
    csrViewIf.vector                view,
    targetIf.src                    out
);

    tvecU                   selVec;
    logic [`REDIR_XLEN-1:0] vecTarget;
    logic                   validQ;
    logic                   takeQ;
    logic [`REDIR_XLEN-1:0] targetQ;

    // tvec of the target privilege level.
    always_comb begin
        unique case (flags.priv)
            privMachine:    selVec = view.mtvec;
            privSupervisor: selVec = view.stvec;
            privUser:       selVec = view.utvec;
            default:        selVec = '0;
        endcase
    end

    // vectored mode only applies to interrupts.
    // exceptions always land on base.
    always_comb begin
        if (selVec.fields.mode == 2'b01 && flags.isInterrupt) begin
            vecTarget = {selVec.fields.base +
                         {{(`REDIR_XLEN-2-`REDIR_CODEW){1'b0}}, code}, 2'b00};
        end else begin
            vecTarget = {selVec.fields.base, 2'b00};
        end
    end

    // one-entry stage.
    // free when empty or draining this cycle.
    assign inReady = !validQ || out.ready;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (inValid && inReady) begin
            validQ <= 1'b1;
        end else if (out.ready) begin
            validQ <= 1'b0;
        end
    end

    // result payload.
    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            takeQ   <= flags.trap;
            targetQ <= vecTarget;
        end
    end

    assign out.valid  = validQ;
    assign out.take   = takeQ;
    assign out.target = targetQ;

endmodule
